//--- rtl/fpu_lane_add.sv
module fpu_lane_add (
  input  logic               clk,
  input  fpu_pkg::lane_t     a,
  input  fpu_pkg::lane_t     b,
  input  logic               negate_b,
  output fpu_pkg::lane_res_t res
);
  import fpu_pkg::*;

  logic                    sa, sb;
  logic [EXP_W-1:0]        ea, eb;
  logic                    a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
  ext_sig_t                sig_a, sig_b;
  logic                    a_big;
  logic                    big_s;
  logic [EXP_W-1:0]        big_e, sml_e, exp_diff;
  ext_sig_t                big_x, sml_x, sml_al, norm;
  logic [2*EXT_W-1:0]      sml_shifted;
  shamt_t                  sh_amt, lz;
  logic [EXT_W:0]          sum;
  logic signed [EXP_W+1:0] exp_n;
  lane_res_t               res_d;

  function automatic shamt_t lead_zeros(input ext_sig_t v);
    shamt_t n;
    logic   found;
    n = '0;
    found = 1'b0;
    for (int i = EXT_W - 1; i >= 0; i--) begin
      if (!found && v[i]) begin
        n = shamt_t'(EXT_W - 1 - i);
        found = 1'b1;
      end
    end
    return n;
  endfunction

  // ========================================
  // unpack and classify
  // ========================================
  assign sa = a[LANE_W-1];
  assign sb = b[LANE_W-1] ^ negate_b;
  assign ea = a[LANE_W-2:FRAC_W];
  assign eb = b[LANE_W-2:FRAC_W];

  assign a_zero = (ea == '0);                   // denormals count as zero
  assign b_zero = (eb == '0);
  assign a_inf  = (ea == EXP_ONES) && (a[FRAC_W-1:0] == '0);
  assign b_inf  = (eb == EXP_ONES) && (b[FRAC_W-1:0] == '0);
  assign a_nan  = (ea == EXP_ONES) && (a[FRAC_W-1:0] != '0);
  assign b_nan  = (eb == EXP_ONES) && (b[FRAC_W-1:0] != '0);

  assign sig_a = a_zero ? '0 : {1'b1, a[FRAC_W-1:0], 3'b000};
  assign sig_b = b_zero ? '0 : {1'b1, b[FRAC_W-1:0], 3'b000};

  // order by magnitude so the difference never goes negative
  assign a_big = (a[LANE_W-2:0] >= b[LANE_W-2:0]);
  assign big_s = a_big ? sa : sb;
  assign big_e = a_big ? ea : eb;
  assign sml_e = a_big ? eb : ea;
  assign big_x = a_big ? sig_a : sig_b;
  assign sml_x = a_big ? sig_b : sig_a;

  // ========================================
  // align, add, normalize
  // ========================================
  always_comb begin
    exp_diff    = big_e - sml_e;
    sh_amt      = (exp_diff > EXT_W) ? shamt_t'(EXT_W) : shamt_t'(exp_diff);
    sml_shifted = {sml_x, {EXT_W{1'b0}}} >> sh_amt;
    sml_al      = {sml_shifted[2*EXT_W-1:EXT_W+1],
                   sml_shifted[EXT_W] | (|sml_shifted[EXT_W-1:0])};  // sticky keeps lost bits
    if (sa ^ sb) begin
      sum = {1'b0, big_x} - {1'b0, sml_al};
    end else begin
      sum = {1'b0, big_x} + {1'b0, sml_al};
    end
    lz = lead_zeros(sum[EXT_W-1:0]);
    if (sum[EXT_W]) begin
      norm  = {sum[EXT_W:2], sum[1] | sum[0]};
      exp_n = {2'b00, big_e} + 10'd1;
    end else begin
      norm  = sum[EXT_W-1:0] << lz;
      exp_n = {2'b00, big_e} - {{(EXP_W+2-SHAMT_W){1'b0}}, lz};
    end
  end

  // ========================================
  // special cases and truncation
  // ========================================
  always_comb begin
    res_d.flags = '0;
    if (a_nan || b_nan || (a_inf && b_inf && (sa ^ sb))) begin
      res_d.value = QNAN;
      res_d.flags[FLG_INVALID] = 1'b1;
    end else if (a_inf) begin
      res_d.value = {sa, EXP_ONES, {FRAC_W{1'b0}}};
    end else if (b_inf) begin
      res_d.value = {sb, EXP_ONES, {FRAC_W{1'b0}}};
    end else if (sum == '0) begin
      res_d.value = {a_zero & b_zero & sa & sb, {(LANE_W-1){1'b0}}};  // cancellation is +0
    end else if (exp_n <= 0) begin
      res_d.value = {big_s, {(LANE_W-1){1'b0}}};
      res_d.flags[FLG_UNDERFLOW] = 1'b1;
      res_d.flags[FLG_INEXACT]   = 1'b1;
    end else if (exp_n >= $signed({2'b00, EXP_ONES})) begin
      res_d.value = {big_s, MAX_MAG};           // toward zero stops at the largest finite
      res_d.flags[FLG_OVERFLOW] = 1'b1;
      res_d.flags[FLG_INEXACT]  = 1'b1;
    end else begin
      res_d.value = {big_s, exp_n[EXP_W-1:0], norm[EXT_W-2:3]};
      res_d.flags[FLG_INEXACT] = |norm[2:0];
    end
  end

  always_ff @(posedge clk) begin
    res <= res_d;
  end

endmodule

//--- rtl/fpu_lane_perm.sv
module fpu_lane_perm (
  input  logic                clk,
  input  fpu_pkg::fp_word_t   a,
  input  fpu_pkg::fp_word_t   b,
  input  fpu_pkg::perm_mode_t mode,
  output fpu_pkg::fp_word_t   res
);
  import fpu_pkg::*;

  lane_t    a_lo, a_hi, b_lo;
  fp_word_t perm_d;

  assign a_lo = a[LANE_W-1:0];
  assign a_hi = a[WORD_W-1:LANE_W];
  assign b_lo = b[LANE_W-1:0];

  always_comb begin
    case (mode)
      PERM_PASS: perm_d = {a_hi, a_lo};
      PERM_SWAP: perm_d = {a_lo, a_hi};
      PERM_DUP:  perm_d = {a_lo, a_lo};
      PERM_PACK: perm_d = {b_lo, a_lo};         // b goes to the high lane
      default:   perm_d = a;
    endcase
  end

  always_ff @(posedge clk) begin
    res <= perm_d;
  end

endmodule

//--- rtl/fpu_op_decode.sv
module fpu_op_decode (
  input  logic            clk,
  input  logic            rst,
  input  fpu_pkg::issue_t issue,
  output fpu_pkg::ctrl_t  ctrl
);
  import fpu_pkg::*;

  op_code_t op_norm;
  ctrl_t    ctrl_d;

  // the spare opcode behaves as an add
  assign op_norm = (issue.op == OP_SUB || issue.op == OP_PERM) ? issue.op : OP_ADD;

  always_comb begin
    ctrl_d.valid    = issue.valid;
    ctrl_d.is_perm  = 1'b0;
    ctrl_d.negate_b = 1'b0;
    ctrl_d.perm     = issue.perm;
    ctrl_d.tag      = issue.tag;
    case (op_norm)
      OP_SUB: begin
        ctrl_d.negate_b = 1'b1;                 // subtract is add with b's sign flipped
      end
      OP_PERM: begin
        ctrl_d.is_perm = 1'b1;
      end
      default: begin
        ctrl_d.negate_b = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    ctrl <= ctrl_d;
    if (rst) begin
      ctrl.valid <= 1'b0;
    end
  end

endmodule

//--- rtl/fpu_operand_fwd.sv
module fpu_operand_fwd (
  input  logic              clk,
  input  logic              rst,
  input  fpu_pkg::fp_word_t value,
  input  fpu_pkg::fwd_sel_t sel,
  input  fpu_pkg::fp_word_t fwd_bus [fpu_pkg::FWD_BUSES],
  output fpu_pkg::fp_word_t operand
);
  import fpu_pkg::*;

  fp_word_t             bus_dly [FWD_BUSES];
  logic                 dly_ok;
  logic [FWD_IDX_W-1:0] bus_no;
  fp_word_t             pick;

  assign bus_no = sel[FWD_IDX_W-1:0];

  always_comb begin
    if (!sel[FWD_EN_BIT]) begin
      pick = value;
    end else if (sel[FWD_DLY_BIT]) begin
      pick = dly_ok ? bus_dly[bus_no] : '0;     // no bus value was captured before reset ended
    end else begin
      pick = fwd_bus[bus_no];
    end
  end

  always_ff @(posedge clk) begin
    bus_dly <= fwd_bus;                         // each copy keeps its own delayed buses
    operand <= pick;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dly_ok <= 1'b0;
    end else begin
      dly_ok <= 1'b1;
    end
  end

endmodule

//--- rtl/fpu_pkg.sv
package fpu_pkg;

  // ========================================
  // widths
  // ========================================
  localparam int LANE_W    = 32;
  localparam int WORD_W    = 2 * LANE_W;
  localparam int TAG_W     = 6;
  localparam int FWD_BUSES = 4;
  localparam int FWD_IDX_W = $clog2(FWD_BUSES);
  localparam int NUM_FLAGS = 4;

  localparam int FRAC_W  = 23;
  localparam int EXP_W   = 8;
  localparam int EXT_W   = FRAC_W + 4;          // hidden bit, fraction, guard, round, sticky
  localparam int SHAMT_W = $clog2(EXT_W + 1);

  typedef logic [LANE_W-1:0]     lane_t;
  typedef logic [WORD_W-1:0]     fp_word_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [3:0]            fwd_sel_t;
  typedef logic [1:0]            op_code_t;
  typedef logic [1:0]            perm_mode_t;
  typedef logic [NUM_FLAGS-1:0]  fflags_t;
  typedef logic [1:0]            exc_no_t;
  typedef logic [EXT_W-1:0]      ext_sig_t;
  typedef logic [SHAMT_W-1:0]    shamt_t;

  // ========================================
  // encodings
  // ========================================
  localparam int FWD_EN_BIT  = 3;                // operand comes from a bus
  localparam int FWD_DLY_BIT = 2;                // use the bus value of the previous edge

  localparam op_code_t OP_ADD  = 2'd0;
  localparam op_code_t OP_SUB  = 2'd1;
  localparam op_code_t OP_PERM = 2'd2;

  localparam perm_mode_t PERM_PASS = 2'd0;
  localparam perm_mode_t PERM_SWAP = 2'd1;
  localparam perm_mode_t PERM_DUP  = 2'd2;
  localparam perm_mode_t PERM_PACK = 2'd3;

  localparam int FLG_INVALID   = 0;
  localparam int FLG_OVERFLOW  = 1;
  localparam int FLG_UNDERFLOW = 2;
  localparam int FLG_INEXACT   = 3;

  localparam lane_t             QNAN     = 32'h7FC0_0000;
  localparam logic [LANE_W-2:0] MAX_MAG  = 31'h7F7F_FFFF;  // largest finite magnitude
  localparam logic [EXP_W-1:0]  EXP_ONES = '1;

  // ========================================
  // stage structs
  // ========================================
  typedef struct packed {
    logic       valid;
    op_code_t   op;
    perm_mode_t perm;
    tag_t       tag;
    fp_word_t   a;
    fp_word_t   b;
    fwd_sel_t   fwd_a;
    fwd_sel_t   fwd_b;
  } issue_t;

  typedef struct packed {
    logic       valid;
    logic       is_perm;
    logic       negate_b;
    perm_mode_t perm;
    tag_t       tag;
  } ctrl_t;

  typedef struct packed {
    lane_t   value;
    fflags_t flags;
  } lane_res_t;

endpackage

//--- rtl/fpu_port.sv
module fpu_port (
  input  logic              clk,
  input  logic              rst,
  input  fpu_pkg::issue_t   issue,
  input  fpu_pkg::fp_word_t fwd_bus [fpu_pkg::FWD_BUSES],
  input  fpu_pkg::fflags_t  fp_csr,
  output logic              res_valid,
  output fpu_pkg::tag_t     res_tag,
  output fpu_pkg::fp_word_t res_data,
  output fpu_pkg::fflags_t  res_flags,
  output logic              exc_en,
  output fpu_pkg::exc_no_t  exc_no
);
  import fpu_pkg::*;

  fp_word_t  op_a, op_b;
  ctrl_t     ctrl_s1, ctrl_s2;
  lane_res_t add_lo, add_hi;
  fp_word_t  perm_res;

  // ========================================
  // stage 1: operands and decode
  // ========================================
  fpu_operand_fwd i_fwd_a (.clk, .rst, .value(issue.a), .sel(issue.fwd_a), .fwd_bus,
                           .operand(op_a));
  fpu_operand_fwd i_fwd_b (.clk, .rst, .value(issue.b), .sel(issue.fwd_b), .fwd_bus,
                           .operand(op_b));
  fpu_op_decode i_decode (.clk, .rst, .issue, .ctrl(ctrl_s1));

  // ========================================
  // stage 2: both lanes and the permute
  // ========================================
  fpu_lane_add i_add_lo (.clk, .a(op_a[LANE_W-1:0]), .b(op_b[LANE_W-1:0]),
                         .negate_b(ctrl_s1.negate_b), .res(add_lo));
  fpu_lane_add i_add_hi (.clk, .a(op_a[WORD_W-1:LANE_W]), .b(op_b[WORD_W-1:LANE_W]),
                         .negate_b(ctrl_s1.negate_b), .res(add_hi));
  fpu_lane_perm i_perm (.clk, .a(op_a), .b(op_b), .mode(ctrl_s1.perm), .res(perm_res));

  always_ff @(posedge clk) begin
    ctrl_s2 <= ctrl_s1;                         // travels beside the lane results
    if (rst) begin
      ctrl_s2.valid <= 1'b0;
    end
  end

  // ========================================
  // stage 3: writeback
  // ========================================
  fpu_writeback i_wb (
    .clk, .rst,
    .ctrl(ctrl_s2),
    .add_lo, .add_hi, .perm_res, .fp_csr,
    .res_valid, .res_tag, .res_data, .res_flags, .exc_en, .exc_no
  );

endmodule

//--- rtl/fpu_writeback.sv
module fpu_writeback (
  input  logic               clk,
  input  logic               rst,
  input  fpu_pkg::ctrl_t     ctrl,
  input  fpu_pkg::lane_res_t add_lo,
  input  fpu_pkg::lane_res_t add_hi,
  input  fpu_pkg::fp_word_t  perm_res,
  input  fpu_pkg::fflags_t   fp_csr,
  output logic               res_valid,
  output fpu_pkg::tag_t      res_tag,
  output fpu_pkg::fp_word_t  res_data,
  output fpu_pkg::fflags_t   res_flags,
  output logic               exc_en,
  output fpu_pkg::exc_no_t   exc_no
);
  import fpu_pkg::*;

  fp_word_t data_d;
  fflags_t  flags_d;
  fflags_t  hit;
  exc_no_t  exc_d;

  always_comb begin
    if (ctrl.is_perm) begin
      data_d  = perm_res;
      flags_d = '0;                             // a permute never raises flags
    end else begin
      data_d  = {add_hi.value, add_lo.value};
      flags_d = add_hi.flags | add_lo.flags;
    end
    hit   = flags_d & fp_csr;
    exc_d = '0;
    for (int i = NUM_FLAGS - 1; i >= 0; i--) begin
      if (hit[i]) begin
        exc_d = exc_no_t'(i);                   // last hit wins so the lowest index is kept
      end
    end
  end

  always_ff @(posedge clk) begin
    res_tag   <= ctrl.tag;
    res_data  <= data_d;
    res_flags <= flags_d;
    exc_no    <= exc_d;
    if (rst) begin
      res_valid <= 1'b0;
      exc_en    <= 1'b0;
    end else begin
      res_valid <= ctrl.valid;
      exc_en    <= ctrl.valid && (hit != '0);
    end
  end

endmodule

//--- testbench/fpu_port_asserts.sv
module fpu_port_asserts (
  input logic clk,
  input logic rst,
  input logic issue_valid,
  input logic res_valid,
  input logic exc_en
);

  int fail_cnt = 0;                             // read by the testbench at the end of the run

  a_reset_quiet: assert property (@(posedge clk) rst |=> !res_valid)
    else begin
      $error("res_valid high after a reset edge");
      fail_cnt++;
    end

  // three registers sit between the issue and the result
  a_latency: assert property (@(posedge clk) disable iff (rst)
    res_valid == $past(issue_valid, 3))
    else begin
      $error("res_valid does not follow issue valid by three cycles");
      fail_cnt++;
    end

  a_exc_needs_valid: assert property (@(posedge clk) exc_en |-> res_valid)
    else begin
      $error("exc_en high without a valid result");
      fail_cnt++;
    end

endmodule

bind fpu_port fpu_port_asserts i_asserts (
  .clk, .rst, .issue_valid(issue.valid), .res_valid, .exc_en
);

//--- testbench/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk,
  output logic rst
);

  localparam int PERIOD     = 100;
  localparam int RST_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;                                 // released on a falling edge like the other inputs
  end

endmodule

//--- testbench/tb_fpu_port.sv
module tb_fpu_port;
  import fpu_pkg::*;

  typedef struct packed {
    int       stamp;                            // cycle count when the op was driven
    tag_t     tag;
    fp_word_t data;
    fflags_t  flags;
    logic     exc_en;
    exc_no_t  exc_no;
  } expect_t;

  localparam int    TEST_CYCLES = 1300;         // rough length of all tests together
  localparam int    MAX_CYCLES  = 2 * TEST_CYCLES + 400;
  localparam int    PIPE_CYCLES = 3;
  localparam lane_t ONE         = 32'h3F80_0000;

  logic        clk, rst;
  issue_t      issue;
  fp_word_t    fwd_bus [FWD_BUSES];
  fp_word_t    prev_bus [FWD_BUSES];
  fflags_t     fp_csr;
  logic        res_valid, exc_en;
  tag_t        res_tag, next_tag;
  fp_word_t    res_data, a_w, b_w;
  fflags_t     res_flags;
  exc_no_t     exc_no;
  expect_t     exp_q [$];
  expect_t     got;
  logic [31:0] rng = 32'd10;
  logic [31:0] rv;
  int          cyc, err_cnt, chk_cnt, err_mark, test_cnt;
  // flag raising add operands: invalid, overflow, underflow, inexact, clean
  lane_t flag_a [5] = '{32'h7FC0_0000, 32'h7F7F_FFFF, 32'h0080_0001, ONE, ONE};
  lane_t flag_b [5] = '{ONE, 32'h7F00_0000, 32'h8080_0000, 32'h3380_0001, ONE};

  tb_clk_gen i_clk_gen (.clk, .rst);

  fpu_port i_dut (.clk, .rst, .issue, .fwd_bus, .fp_csr, .res_valid, .res_tag, .res_data,
                  .res_flags, .exc_en, .exc_no);

  // ========================================
  // random values and reference model
  // ========================================
  function automatic logic [31:0] rand32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic lane_t rand_lane();
    logic [31:0] r, f;
    r = rand32();
    f = rand32();
    case (r[3:0])
      4'd0:    return {r[31], 8'h00, f[22:0]};                        // zero or denormal
      4'd1:    return {r[31], 8'hFF, f[4] ? 23'd0 : f[22:0] | 23'd1}; // infinity or NaN
      4'd2:    return {r[31], 8'd247 + 8'(r[6:4]), f[22:0]};
      4'd3:    return {r[31], 8'd1 + 8'(r[6:4]), f[22:0]};
      default: return {r[31], 8'd100 + 8'(r[9:4]), f[22:0]};
    endcase
  endfunction

  function automatic fp_word_t rand_word();
    lane_t hi, lo;
    hi = rand_lane();
    lo = rand_lane();
    return {hi, lo};
  endfunction

  function automatic lane_res_t add_model(input lane_t a, input lane_t b, input logic neg);
    lane_res_t   r;
    logic        sa, sb, sbig;
    logic [7:0]  ea, eb, ebig, esml;
    logic [23:0] ma, mb, mbig, msml;
    logic [65:0] big_v, sml_v, sum, mant;
    int          d, p, e_r;
    sa = a[31];
    sb = b[31] ^ neg;
    ea = a[30:23];
    eb = b[30:23];
    r.flags = '0;
    if ((ea == 8'hFF && a[22:0] != 0) || (eb == 8'hFF && b[22:0] != 0) ||
        (ea == 8'hFF && eb == 8'hFF && sa != sb)) begin
      r.value = QNAN;
      r.flags[FLG_INVALID] = 1'b1;
      return r;
    end
    if (ea == 8'hFF) return '{value: {sa, 8'hFF, 23'd0}, flags: '0};
    if (eb == 8'hFF) return '{value: {sb, 8'hFF, 23'd0}, flags: '0};
    ma = (ea == 0) ? 24'd0 : {1'b1, a[22:0]};  // denormals flush to zero
    mb = (eb == 0) ? 24'd0 : {1'b1, b[22:0]};
    if ({ea, ma} >= {eb, mb}) begin
      {sbig, ebig, mbig, esml, msml} = {sa, ea, ma, eb, mb};
    end else begin
      {sbig, ebig, mbig, esml, msml} = {sb, eb, mb, ea, ma};
    end
    d = int'(ebig) - int'(esml);
    big_v = 66'(mbig) << 40;
    // anything shifted past 40 places only counts as a nonzero tail
    sml_v = (d <= 40) ? 66'(msml) << (40 - d) : 66'(msml != 0);
    sum = (sa == sb) ? big_v + sml_v : big_v - sml_v;
    if (sum == 0) begin
      r.value = {(ma == 0) && (mb == 0) && sa && sb, 31'd0};
      return r;
    end
    p = 65;
    while (!sum[p]) p--;
    e_r = p + int'(ebig) - 63;
    if (e_r <= 0) begin
      r.value = {sbig, 31'd0};
      r.flags[FLG_UNDERFLOW] = 1'b1;
      r.flags[FLG_INEXACT]   = 1'b1;
    end else if (e_r >= 255) begin
      r.value = {sbig, 31'h7F7F_FFFF};
      r.flags[FLG_OVERFLOW] = 1'b1;
      r.flags[FLG_INEXACT]  = 1'b1;
    end else begin
      mant = (p >= 23) ? sum >> (p - 23) : sum << (23 - p);
      r.value = {sbig, 8'(e_r), mant[22:0]};
      r.flags[FLG_INEXACT] = (p > 23) && ((sum & ((66'd1 << (p - 23)) - 66'd1)) != 0);
    end
    return r;
  endfunction

  // bit 3 takes a bus, bit 2 its value from the previous edge
  function automatic fp_word_t pick_operand(input fp_word_t v, input fwd_sel_t s,
                                            input fp_word_t cur [FWD_BUSES],
                                            input fp_word_t prev [FWD_BUSES]);
    if (!s[3]) return v;
    if (s[2]) return prev[s[1:0]];
    return cur[s[1:0]];
  endfunction

  function automatic expect_t model(input issue_t is, input fp_word_t cur [FWD_BUSES],
                                    input fp_word_t prev [FWD_BUSES], input fflags_t csr);
    expect_t   e;
    fp_word_t  a, b;
    lane_res_t lo, hi;
    fflags_t   hit;
    a = pick_operand(is.a, is.fwd_a, cur, prev);
    b = pick_operand(is.b, is.fwd_b, cur, prev);
    e.stamp = 0;
    e.tag = is.tag;
    if (is.op == OP_PERM) begin
      case (is.perm)
        PERM_PASS: e.data = a;
        PERM_SWAP: e.data = {a[31:0], a[63:32]};
        PERM_DUP:  e.data = {a[31:0], a[31:0]};
        default:   e.data = {b[31:0], a[31:0]};
      endcase
      e.flags = '0;
    end else begin
      lo = add_model(a[31:0], b[31:0], is.op == OP_SUB);
      hi = add_model(a[63:32], b[63:32], is.op == OP_SUB);
      e.data = {hi.value, lo.value};
      e.flags = hi.flags | lo.flags;
    end
    hit = e.flags & csr;
    e.exc_en = (hit != 0);
    if (hit[0]) e.exc_no = 2'd0;
    else if (hit[1]) e.exc_no = 2'd1;
    else if (hit[2]) e.exc_no = 2'd2;
    else e.exc_no = 2'd3;
    return e;
  endfunction

  // ========================================
  // stimulus
  // ========================================
  task automatic drive(input issue_t is);
    expect_t e;
    @(negedge clk);
    prev_bus = fwd_bus;                         // the buses seen at the last rising edge
    foreach (fwd_bus[i]) begin
      fwd_bus[i] = rand_word();
    end
    issue = is;
    if (is.valid) begin
      e = model(is, fwd_bus, prev_bus, fp_csr);
      e.stamp = cyc;
      exp_q.push_back(e);
    end
  endtask

  task automatic issue_op(input op_code_t op, input perm_mode_t pm, input fp_word_t a,
                          input fp_word_t b, input fwd_sel_t fa, input fwd_sel_t fb);
    issue_t is;
    is.valid = 1'b1;
    is.op = op;
    is.perm = pm;
    is.tag = next_tag;
    is.a = a;
    is.b = b;
    is.fwd_a = fa;
    is.fwd_b = fb;
    next_tag = next_tag + 1'b1;
    drive(is);
  endtask

  task automatic idle(input int n);
    repeat (n) drive('0);
  endtask

  task automatic drain();
    while (exp_q.size() != 0) idle(1);
    idle(2);
  endtask

  // puts the case in each lane in turn, with 1 + 1 beside it
  task automatic directed(input lane_t a, input lane_t b, input op_code_t op);
    issue_op(op, PERM_PASS, {ONE, a}, {ONE, b}, '0, '0);
    issue_op(op, PERM_PASS, {a, ONE}, {b, ONE}, '0, '0);
  endtask

  task automatic report(input string name);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  // ========================================
  // comparison and timeout
  // ========================================
  task automatic compare_result(input expect_t e);
    chk_cnt++;
    if (res_tag !== e.tag) begin
      $display("ERR %0t: tag %0d, expected %0d", $time, res_tag, e.tag);
      err_cnt++;
    end
    if (res_data !== e.data) begin
      $display("ERR %0t: tag %0d data %h, expected %h", $time, e.tag, res_data, e.data);
      err_cnt++;
    end
    if (res_flags !== e.flags) begin
      $display("ERR %0t: tag %0d flags %b, expected %b", $time, e.tag, res_flags, e.flags);
      err_cnt++;
    end
    if (exc_en !== e.exc_en) begin
      $display("ERR %0t: tag %0d exc_en %b, expected %b", $time, e.tag, exc_en, e.exc_en);
      err_cnt++;
    end
    if (e.exc_en && exc_no !== e.exc_no) begin
      $display("ERR %0t: tag %0d exc_no %0d, expected %0d", $time, e.tag, exc_no, e.exc_no);
      err_cnt++;
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      while (exp_q.size() != 0 && exp_q[0].stamp + PIPE_CYCLES < cyc) begin
        $display("missing result: tag %0d driven in cycle %0d never came back",
                 exp_q[0].tag, exp_q[0].stamp);
        err_cnt++;
        void'(exp_q.pop_front());
      end
      if (res_valid) begin
        if (exp_q.size() == 0 || exp_q[0].stamp + PIPE_CYCLES != cyc) begin
          $display("unexpected result: tag %0d at time %0t was never issued", res_tag, $time);
          err_cnt++;
        end else begin
          got = exp_q.pop_front();
          compare_result(got);
        end
      end
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cyc);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ========================================
  // test sequence
  // ========================================
  initial begin
    issue = '0;
    fp_csr = '0;
    next_tag = '0;
    foreach (fwd_bus[i]) begin
      fwd_bus[i] = '0;
      prev_bus[i] = '0;
    end
    @(negedge rst);

    idle(8);                                    // nothing may come out before the first issue
    for (int i = 0; i < 150; i++) begin
      rv = rand32();
      if (rv[0]) issue_op(op_code_t'(rv[2:1]), rv[4:3], rand_word(), rand_word(), '0, '0);
      else idle(1);
    end
    drain();
    report("idle and gaps");

    directed(32'h7F80_0001, ONE, OP_ADD);
    directed(32'h7F80_0000, 32'h7F80_0000, OP_SUB);
    directed(32'hFF80_0000, 32'h4120_0000, OP_ADD);
    directed(32'h3FC0_0000, 32'h3FC0_0000, OP_SUB);
    directed(32'h7F7F_FFFF, 32'h7F7F_FFFF, OP_ADD);
    directed(32'h0080_0001, 32'h0080_0000, OP_SUB);
    directed(32'h0040_0000, ONE, OP_ADD);
    directed(32'h8000_0001, 32'h0020_0000, OP_ADD);
    directed(ONE, 32'h3380_0001, OP_ADD);
    drain();
    report("directed special cases");

    fp_csr = '1;
    for (int i = 0; i < 400; i++) begin
      rv = rand32();
      a_w = rand_word();
      b_w = (rv[2:0] == 0) ? a_w : rand_word();
      issue_op(rv[3] ? OP_SUB : op_code_t'({rv[4], rv[4]}), PERM_PASS, a_w, b_w, '0, '0);
    end
    drain();
    report("random add and subtract");

    fp_csr = '0;
    for (int i = 0; i < 300; i++) begin
      rv = rand32();
      issue_op(rv[1:0], rv[3:2], rand_word(), rand_word(), rv[7:4], rv[11:8]);
    end
    drain();
    report("operand forwarding");

    fp_csr = '1;
    for (int m = 0; m < 4; m++) begin
      repeat (8) issue_op(OP_PERM, perm_mode_t'(m), rand_word(), rand_word(), '0, '0);
    end
    drain();
    report("permute modes");

    for (int round = 0; round < 16; round++) begin
      rv = rand32();
      fp_csr = (round == 0) ? '0 : rv[3:0];
      repeat (6) begin
        a_w[31:0] = 32'(rand32() % 5);
        b_w[31:0] = 32'(rand32() % 5);
        issue_op(OP_ADD, PERM_PASS, {flag_a[b_w[2:0]], flag_a[a_w[2:0]]},
                 {flag_b[b_w[2:0]], flag_b[a_w[2:0]]}, '0, '0);
      end
      drain();
    end
    report("exception masking");

    err_cnt += i_dut.i_asserts.fail_cnt;        // failed concurrent assertions count as errors
    $display("summary: %0d tests, %0d results checked, %0d errors", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
rtl/fpu_pkg.sv
rtl/fpu_operand_fwd.sv
rtl/fpu_op_decode.sv
rtl/fpu_lane_add.sv
rtl/fpu_lane_perm.sv
rtl/fpu_writeback.sv
rtl/fpu_port.sv
testbench/tb_clk_gen.sv
testbench/fpu_port_asserts.sv
testbench/tb_fpu_port.sv
